// ==== source/bulk_move_config.svh ====
// width, size and latency macros for the data mover.

`ifndef BULK_MOVE_CONFIG_SVH
`define BULK_MOVE_CONFIG_SVH

// ----------------------------------------
// word and address geometry
// ----------------------------------------

// data word width in bits.
`define BM_DATA_WIDTH 32
// buffer address width, 64 words per RAM.
`define BM_ADDR_WIDTH 6
// words moved per transfer.
`define BM_WORD_COUNT 64

// ----------------------------------------
// FIFO and RAM timing
// ----------------------------------------

// FIFO entries, power of two.
`define BM_FIFO_DEPTH 16
// free slots left when almost_full rises.
`define BM_AF_MARGIN 4
// cycles from read address to read data.
`define BM_RAM_LATENCY 2

`endif

// ==== source/bulk_move_pkg.sv ====
// shared types for the data mover, words, addresses, counters, FIFO levels and FSM states.

`include "bulk_move_config.svh"

package bulk_move_pkg;

    // one data word.
    typedef logic [`BM_DATA_WIDTH-1:0] data_t;

    // buffer RAM address.
    typedef logic [`BM_ADDR_WIDTH-1:0] addr_t;

    // word counter, one bit wider than an address.
    // holds the full word count without wrapping.
    typedef logic [`BM_ADDR_WIDTH:0] count_t;

    // FIFO fill level, 0 up to the full depth.
    typedef logic [$clog2(`BM_FIFO_DEPTH):0] level_t;

    // states of the read sequencer and the result writer.
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } mover_state_t;

endpackage

// ==== source/dual_port_ram.sv ====
// buffer RAM with one write port and a two-cycle registered read port.

`timescale 1ns/10ps

`include "bulk_move_config.svh"

module dual_port_ram (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  bulk_move_pkg::addr_t waddr,
    input  bulk_move_pkg::data_t wdata,
    input  bulk_move_pkg::addr_t raddr,
    output bulk_move_pkg::data_t rdata
);

    // one entry per address.
    localparam int DEPTH = 1 << `BM_ADDR_WIDTH;

    bulk_move_pkg::data_t mem [0:DEPTH-1];
    // first read stage, array output.
    bulk_move_pkg::data_t rd_stage;

    // write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rd_stage <= mem[raddr];
    end

    // second read stage.
    // data shows up two cycles after raddr.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= rd_stage;
        end
    end

endmodule

// ==== source/ram_to_fifo.sv ====
// read sequencer that streams a block of RAM words into the FIFO.

`timescale 1ns/10ps

`include "bulk_move_config.svh"

module ram_to_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 last_read,
    output bulk_move_pkg::addr_t ram_addr,
    input  bulk_move_pkg::data_t ram_data,
    output logic                 fifo_push,
    output bulk_move_pkg::data_t fifo_wdata,
    input  logic                 almost_full
);

    bulk_move_pkg::mover_state_t state;
    // reads issued so far in this block.
    bulk_move_pkg::count_t       read_cnt;
    // one bit per read still inside the RAM pipeline.
    logic [`BM_RAM_LATENCY-1:0]  push_dly;

    logic issue;
    logic final_read;

    // ----------------------------------------
    // read issue
    // ----------------------------------------

    // a read goes out every running cycle the FIFO has room.
    assign issue = (state == bulk_move_pkg::RUN) && !almost_full;

    // the read that completes the block.
    assign final_read = issue && (read_cnt == `BM_WORD_COUNT - 1);

    // address follows the counter directly.
    assign ram_addr = read_cnt[`BM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= bulk_move_pkg::IDLE;
            read_cnt  <= '0;
            last_read <= 1'b0;
        end else begin
            // pulses the cycle after the final read.
            last_read <= final_read;
            case (state)
                bulk_move_pkg::IDLE: begin
                    if (start) begin
                        state    <= bulk_move_pkg::RUN;
                        read_cnt <= '0;
                    end
                end
                bulk_move_pkg::RUN: begin
                    if (issue) begin
                        read_cnt <= read_cnt + 1'b1;
                    end
                    if (final_read) begin
                        state <= bulk_move_pkg::IDLE;
                    end
                end
                default: state <= bulk_move_pkg::IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // push alignment
    // ----------------------------------------

    // shift the issue flag through the RAM latency.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push_dly <= '0;
        end else begin
            push_dly <= {push_dly[`BM_RAM_LATENCY-2:0], issue};
        end
    end

    // push lands with the data of its read.
    assign fifo_push  = push_dly[`BM_RAM_LATENCY-1];
    assign fifo_wdata = ram_data;

endmodule

// ==== source/sync_fifo.sv ====
// single-clock first-word fall-through FIFO with a registered almost_full flag.

`timescale 1ns/10ps

`include "bulk_move_config.svh"

module sync_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  bulk_move_pkg::data_t wdata,
    input  logic                 pop,
    output bulk_move_pkg::data_t rdata,
    output logic                 empty,
    output logic                 almost_full
);

    localparam int PTR_W = $clog2(`BM_FIFO_DEPTH);

    bulk_move_pkg::data_t   mem [0:`BM_FIFO_DEPTH-1];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    bulk_move_pkg::level_t  level;
    bulk_move_pkg::level_t  level_next;

    logic full;
    logic do_push;
    logic do_pop;

    assign empty = (level == '0);
    assign full  = (level == `BM_FIFO_DEPTH);

    // drop requests that would over- or underflow.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head word shown before the pop.
    assign rdata = mem[rd_ptr];

    // ----------------------------------------
    // storage and pointers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap at the power-of-two depth.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // fill level
    // ----------------------------------------

    // push and pop together leave the level alone.
    always_comb begin
        level_next = level;
        case ({do_push, do_pop})
            2'b10:   level_next = level + 1'b1;
            2'b01:   level_next = level - 1'b1;
            default: level_next = level;
        endcase
    end

    // flag rises with AF_MARGIN slots still free.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level       <= '0;
            almost_full <= 1'b0;
        end else begin
            level       <= level_next;
            almost_full <= (level_next >= `BM_FIFO_DEPTH - `BM_AF_MARGIN);
        end
    end

endmodule

// ==== source/axpy_stage.sv ====
// two-stage a*x+b kernel fed from the FIFO head.

`timescale 1ns/10ps

module axpy_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 empty,
    input  bulk_move_pkg::data_t rdata,
    output logic                 pop,
    input  logic                 hold,
    input  bulk_move_pkg::data_t coef_a,
    input  bulk_move_pkg::data_t coef_b,
    output logic                 res_valid,
    output bulk_move_pkg::data_t res_data
);

    // stage valid flags.
    logic                 mul_valid;
    logic                 add_valid;
    // stage payloads.
    bulk_move_pkg::data_t product;
    bulk_move_pkg::data_t sum;

    // take the head word whenever the consumer is not stalling.
    assign pop = !empty && !hold;

    // ----------------------------------------
    // pipeline control
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mul_valid <= 1'b0;
            add_valid <= 1'b0;
        end else begin
            mul_valid <= pop;
            add_valid <= mul_valid;
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------

    // low word of the product only, then add b mod 2^32.
    always_ff @(posedge clk) begin
        product <= rdata * coef_a;
        sum     <= product + coef_b;
    end

    // result two cycles after its pop.
    assign res_valid = add_valid;
    assign res_data  = sum;

endmodule

// ==== source/fifo_to_ram.sv ====
// result writer that fills the output RAM and reports busy and done.

`timescale 1ns/10ps

`include "bulk_move_config.svh"

module fifo_to_ram (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 res_valid,
    input  bulk_move_pkg::data_t res_data,
    output logic                 ram_we,
    output bulk_move_pkg::addr_t ram_waddr,
    output bulk_move_pkg::data_t ram_wdata,
    output logic                 busy,
    output logic                 done
);

    bulk_move_pkg::mover_state_t state;
    // results written in this block.
    bulk_move_pkg::count_t       wr_cnt;

    logic final_write;

    // write straight through in the cycle of res_valid.
    assign ram_we      = res_valid && (state == bulk_move_pkg::RUN);
    assign ram_waddr   = wr_cnt[`BM_ADDR_WIDTH-1:0];
    assign ram_wdata   = res_data;
    assign final_write = ram_we && (wr_cnt == `BM_WORD_COUNT - 1);

    assign busy = (state == bulk_move_pkg::RUN);

    // busy drops on the same edge that raises done.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= bulk_move_pkg::IDLE;
            wr_cnt <= '0;
            done   <= 1'b0;
        end else begin
            done <= final_write;
            if (state == bulk_move_pkg::IDLE) begin
                if (start) begin
                    state  <= bulk_move_pkg::RUN;
                    wr_cnt <= '0;
                end
            end else begin
                if (ram_we) begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
                if (final_write) begin
                    state <= bulk_move_pkg::IDLE;
                end
            end
        end
    end

endmodule

// ==== source/bulk_move_top.sv ====
// top level, input RAM, read sequencer, FIFO, a*x+b kernel, result writer and output RAM.

`timescale 1ns/10ps

module bulk_move_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_we,
    input  bulk_move_pkg::addr_t load_addr,
    input  bulk_move_pkg::data_t load_data,
    input  logic                 start,
    input  bulk_move_pkg::data_t coef_a,
    input  bulk_move_pkg::data_t coef_b,
    input  logic                 hold,
    input  bulk_move_pkg::addr_t rd_addr,
    output bulk_move_pkg::data_t rd_data,
    output logic                 busy,
    output logic                 done
);

    // start pulse that passed the busy check.
    logic                 start_ok;
    // observed only by the bound checker.
    logic                 last_read;

    // input side.
    bulk_move_pkg::addr_t in_raddr;
    bulk_move_pkg::data_t in_rdata;
    logic                 fifo_push;
    bulk_move_pkg::data_t fifo_wdata;
    logic                 almost_full;

    // kernel side.
    logic                 fifo_pop;
    logic                 fifo_empty;
    bulk_move_pkg::data_t fifo_rdata;
    logic                 res_valid;
    bulk_move_pkg::data_t res_data;

    // output side.
    logic                 out_we;
    bulk_move_pkg::addr_t out_waddr;
    bulk_move_pkg::data_t out_wdata;

    // a start during a transfer is dropped for both movers.
    assign start_ok = start && !busy;

    // ----------------------------------------
    // input side
    // ----------------------------------------

    // host loads, sequencer reads.
    dual_port_ram i_in_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (load_we),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (in_raddr),
        .rdata (in_rdata)
    );

    ram_to_fifo i_ram_to_fifo (
        .clk         (clk),
        .rst         (rst),
        .start       (start_ok),
        .last_read   (last_read),
        .ram_addr    (in_raddr),
        .ram_data    (in_rdata),
        .fifo_push   (fifo_push),
        .fifo_wdata  (fifo_wdata),
        .almost_full (almost_full)
    );

    sync_fifo i_sync_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (fifo_push),
        .wdata       (fifo_wdata),
        .pop         (fifo_pop),
        .rdata       (fifo_rdata),
        .empty       (fifo_empty),
        .almost_full (almost_full)
    );

    // ----------------------------------------
    // kernel and output side
    // ----------------------------------------

    axpy_stage i_axpy_stage (
        .clk       (clk),
        .rst       (rst),
        .empty     (fifo_empty),
        .rdata     (fifo_rdata),
        .pop       (fifo_pop),
        .hold      (hold),
        .coef_a    (coef_a),
        .coef_b    (coef_b),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    // writer owns busy and done for the whole transfer.
    fifo_to_ram i_fifo_to_ram (
        .clk       (clk),
        .rst       (rst),
        .start     (start_ok),
        .res_valid (res_valid),
        .res_data  (res_data),
        .ram_we    (out_we),
        .ram_waddr (out_waddr),
        .ram_wdata (out_wdata),
        .busy      (busy),
        .done      (done)
    );

    // writer fills, host reads back.
    dual_port_ram i_out_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (out_we),
        .waddr (out_waddr),
        .wdata (out_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

// ==== dv/bulk_move_asserts.sv ====
// concurrent protocol checks on the data mover top-level ports, bound into the top level.

`timescale 1ns/10ps

module bulk_move_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done,
    input logic last_read
);

    // a start was accepted at least once since reset.
    logic started;

    // one sticky flag per property.
    logic idle_bad  = 1'b0;
    logic pulse_bad = 1'b0;
    logic end_bad   = 1'b0;
    logic rise_bad  = 1'b0;
    logic read_bad  = 1'b0;
    // seen by the testbench monitor.
    logic any_failed;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
        end else if (start && !busy) begin
            started <= 1'b1;
        end
    end

    assign any_failed = idle_bad || pulse_bad || end_bad || rise_bad || read_bad;

    // ----------------------------------------
    // busy and done protocol
    // ----------------------------------------

    // quiet until the first accepted start.
    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> !busy && !done)
        else begin
            $error("busy or done seen before any start");
            idle_bad = 1'b1;
        end

    // done lasts one cycle.
    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else begin
            $error("done held for more than one cycle");
            pulse_bad = 1'b1;
        end

    // busy falls together with done.
    done_ends_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy && $past(busy))
        else begin
            $error("done not aligned with the fall of busy");
            end_bad = 1'b1;
        end

    // a transfer only begins on a start pulse.
    busy_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(start))
        else begin
            $error("busy rose without a start pulse");
            rise_bad = 1'b1;
        end

    // reads finish while the writer is still working.
    last_read_in_transfer: assert property (@(posedge clk) disable iff (rst)
        last_read |-> busy)
        else begin
            $error("last read seen outside a transfer");
            read_bad = 1'b1;
        end

endmodule

// ==== dv/bulk_move_tb.sv ====
// testbench for the data mover, clock, reset, LFSR stimulus, a*x+b model and readback checks.

`timescale 1ns/10ps

`include "bulk_move_config.svh"

module bulk_move_tb;

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          SETTLE_CYCLES  = 20;
    localparam logic [31:0] LFSR_SEED      = 32'heb8d7981;
    // x^32 + x^22 + x^2 + x + 1.
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

    logic                 clk;
    logic                 rst;
    logic                 load_we;
    bulk_move_pkg::addr_t load_addr;
    bulk_move_pkg::data_t load_data;
    logic                 start;
    bulk_move_pkg::data_t coef_a;
    bulk_move_pkg::data_t coef_b;
    logic                 hold;
    bulk_move_pkg::addr_t rd_addr;
    bulk_move_pkg::data_t rd_data;
    logic                 busy;
    logic                 done;

    logic [31:0]          lfsr;
    // model output for the block in flight.
    bulk_move_pkg::data_t expected [0:`BM_WORD_COUNT-1];

    bulk_move_top i_bulk_move_top (
        .clk       (clk),
        .rst       (rst),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .coef_a    (coef_a),
        .coef_b    (coef_b),
        .hold      (hold),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    bind bulk_move_top bulk_move_asserts i_bulk_move_asserts (.*);

    always #50 clk = ~clk;

    // ----------------------------------------
    // random source
    // ----------------------------------------

    // one Galois shift, taps fold in when a one leaves.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // one step per bit taken.
    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // ----------------------------------------
    // failure reporting
    // ----------------------------------------

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        stop_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("Error at %0d ns: %s", $time, what);
        stop_with_failure();
    endtask

    // protocol properties raise a flag in the bound checker.
    always @(negedge clk) begin
        if (i_bulk_move_top.i_bulk_move_asserts.any_failed) begin
            report_error("a protocol assertion on the top-level ports fired");
        end
    end

    // ----------------------------------------
    // stimulus and model
    // ----------------------------------------

    // fills the input RAM and records a*x+b mod 2^32 per word.
    task automatic load_block(input bulk_move_pkg::data_t a, input bulk_move_pkg::data_t b);
        logic [31:0] word;
        for (int i = 0; i < `BM_WORD_COUNT; i++) begin
            draw_bits(32, word);
            load_we     = 1'b1;
            load_addr   = bulk_move_pkg::addr_t'(i);
            load_data   = word;
            expected[i] = word * a + b;
            @(negedge clk);
        end
        load_we = 1'b0;
    endtask

    // one transfer, optionally with a stalling consumer or a repeated start.
    task automatic run_transfer(input bit random_hold, input bit second_start);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] coin;
        bit          finished;
        int          done_cnt;
        draw_bits(32, a);
        draw_bits(32, b);
        coef_a = a;
        coef_b = b;
        load_block(a, b);
        done_cnt = 0;
        finished = 1'b0;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else report_mismatch("busy", 32'd1, 32'(busy));
        for (int cycle = 0; cycle < TIMEOUT_CYCLES && !finished; cycle++) begin
            if (random_hold) begin
                draw_bits(1, coin);
                hold = coin[0];
            end
            // held through the whole transfer.
            // also covers the gap after the last read.
            start = second_start;
            if (start) begin
                assert (busy) else report_error("repeated start fell outside a transfer");
            end
            @(negedge clk);
            if (done) begin
                done_cnt++;
                finished = 1'b1;
            end
        end
        hold  = 1'b0;
        start = 1'b0;
        if (!finished) begin
            report_error("timeout waiting for done");
        end
        // no second transfer and no extra done.
        for (int cycle = 0; cycle < SETTLE_CYCLES; cycle++) begin
            @(negedge clk);
            if (done) begin
                done_cnt++;
            end
            assert (!busy) else report_mismatch("busy", 32'd0, 32'(busy));
        end
        assert (done_cnt == 1) else report_mismatch("done pulse count", 32'd1, done_cnt);
    endtask

    // read port data shows up two cycles after rd_addr.
    task automatic check_results();
        for (int i = 0; i < `BM_WORD_COUNT; i++) begin
            rd_addr = bulk_move_pkg::addr_t'(i);
            @(negedge clk);
            @(negedge clk);
            assert (rd_data == expected[i])
                else report_mismatch($sformatf("rd_data[%0d]", i), expected[i], rd_data);
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        coef_a    = '0;
        coef_b    = '0;
        hold      = 1'b0;
        rd_addr   = '0;
        lfsr      = LFSR_SEED;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // idle stretch, watched by the bound checker.
        repeat (10) @(negedge clk);
        // plain transfer.
        run_transfer(1'b0, 1'b0);
        check_results();
        // consumer stalls at random.
        run_transfer(1'b1, 1'b0);
        check_results();
        // start repeated mid-transfer.
        run_transfer(1'b0, 1'b1);
        check_results();
        // fresh coefficients afterwards.
        run_transfer(1'b1, 1'b0);
        check_results();
        if (i_bulk_move_top.i_bulk_move_asserts.any_failed) begin
            stop_with_failure();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+source
source/bulk_move_pkg.sv
source/dual_port_ram.sv
source/ram_to_fifo.sv
source/sync_fifo.sv
source/axpy_stage.sv
source/fifo_to_ram.sv
source/bulk_move_top.sv
dv/bulk_move_asserts.sv
dv/bulk_move_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bulk_move_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
